/* compile.f */
fetch_pkg.sv
pc_select.sv
fetch_fifo.sv
outstanding_counter.sv
fetch_bus_fsm.sv
prefetch_buffer.sv
if_stage.sv
tb_imem.sv
tb_if_stage.sv

/* fetch_bus_fsm.sv */
// instruction bus request fsm
module fetch_bus_fsm (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,          // fetching enabled
  input  logic                  branch_i,       // new target this cycle
  input  logic [31:0]           branch_addr_i,
  input  logic                  space_i,        // room for one more word
  input  fetch_pkg::instr_rsp_t bus_rsp_i,
  output fetch_pkg::instr_req_t bus_req_o,
  output logic                  grant_o
);
  import fetch_pkg::*;

  bus_state_e  state_q;
  bus_state_e  state_n;
  logic [31:0] addr_q;         // address of the next request
  logic        pend_q;         // redirect waiting for the current grant
  logic [31:0] pend_addr_q;
  logic        issue;
  logic        req;

  // no new request in a branch cycle, addr_q is stale until the edge
  assign issue = req_i & space_i & ~branch_i;

  //////////////////////////////////////////////////
  // request control
  //////////////////////////////////////////////////
  always_comb begin
    state_n = state_q;
    req     = 1'b0;
    unique case (state_q)
      BUS_IDLE, BUS_WAIT_RVALID: begin
        if (issue) begin
          req     = 1'b1;
          state_n = bus_rsp_i.gnt ? BUS_WAIT_RVALID : BUS_WAIT_GNT;
        end else if (state_q == BUS_WAIT_RVALID && bus_rsp_i.rvalid) begin
          state_n = BUS_IDLE;   // nothing more requested
        end
      end
      BUS_WAIT_GNT: begin
        req = 1'b1;             // held until granted, even over a branch
        if (bus_rsp_i.gnt) state_n = BUS_WAIT_RVALID;
      end
      default: state_n = BUS_IDLE;
    endcase
  end

  assign grant_o   = req & bus_rsp_i.gnt;
  assign bus_req_o = '{req: req, addr: addr_q};

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= BUS_IDLE;
      addr_q  <= '0;
      pend_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      if (branch_i && req && !bus_rsp_i.gnt) begin
        pend_q <= 1'b1;                // retarget after the grant
      end else if (branch_i) begin
        addr_q <= branch_addr_i;
        pend_q <= 1'b0;
      end else if (grant_o) begin
        addr_q <= pend_q ? pend_addr_q : addr_q + 32'd4;
        pend_q <= 1'b0;
      end
    end
  end

  // redirect target parked during wait_gnt
  always_ff @(posedge clk) begin
    if (branch_i) pend_addr_q <= branch_addr_i;
  end

  //////////////////////////////////////////////////
  // bus rule
  //////////////////////////////////////////////////
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_o.req && !bus_rsp_i.gnt |=> bus_req_o.req && $stable(bus_req_o.addr))
    else $error("fetch_bus_fsm: request dropped or moved before grant");

endmodule

/* fetch_fifo.sv */
// instruction word fifo
module fetch_fifo (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        flush_i,      // drop everything, beats push
  input  logic                        push_i,
  input  logic [31:0]                 push_data_i,
  input  logic                        pop_i,
  output logic                        valid_o,
  output logic [31:0]                 rdata_o,
  output logic [fetch_pkg::CNT_W-1:0] count_o
);
  import fetch_pkg::*;

  logic [31:0]                   mem_q [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
  logic [CNT_W-1:0]              count_q;
  logic                          do_push;
  logic                          do_pop;

  // circular pointer step
  function automatic logic [$clog2(FIFO_DEPTH)-1:0] next_ptr(
    input logic [$clog2(FIFO_DEPTH)-1:0] ptr
  );
    return (ptr == FIFO_DEPTH - 1) ? '0 : ptr + 1'b1;
  endfunction

  assign valid_o = (count_q != '0);
  assign rdata_o = mem_q[rd_ptr_q];   // head word, valid with valid_o
  assign count_o = count_q;

  assign do_push = push_i & ~flush_i;
  assign do_pop  = pop_i & valid_o & ~flush_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;   // none or both
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  // request gating upstream must keep us from overflowing
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    do_push && !do_pop |-> count_q < FIFO_DEPTH)
    else $error("fetch_fifo: push while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> valid_o)  // consumer only pops a presented word
    else $error("fetch_fifo: pop while empty");

endmodule

/* fetch_pkg.sv */
// instruction fetch definitions
package fetch_pkg;

  //////////////////////////////////////////////////
  // buffer sizing
  //////////////////////////////////////////////////
  localparam int FIFO_DEPTH = 2;                        // words held ahead of decode
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);   // counts 0..FIFO_DEPTH

  //////////////////////////////////////////////////
  // selector encodings
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    PC_BOOT,        // boot address after req
    PC_JUMP,        // jump resolved in decode
    PC_BRANCH,      // branch resolved in execute
    PC_EXCEPTION,   // trap handler, see exc_pc_mux_e
    PC_MRET,        // back to mepc
    PC_DRET,        // back to depc
    PC_FENCEI       // refetch pc + 4
  } pc_mux_e;

  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION,  // synchronous trap, base only
    EXC_PC_IRQ,        // vectored interrupt
    EXC_PC_DEBUG       // debug module halt address
  } exc_pc_mux_e;

  typedef enum logic [0:0] {
    TRAP_MACHINE,
    TRAP_USER          // reserved, handled as machine
  } trap_mux_e;

  //////////////////////////////////////////////////
  // state machines
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {BUS_IDLE, BUS_WAIT_GNT, BUS_WAIT_RVALID} bus_state_e;
  typedef enum logic [0:0] {ISSUE_IDLE, ISSUE_WAIT} issue_state_e;

  //////////////////////////////////////////////////
  // instruction bus and address sources
  //////////////////////////////////////////////////
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } instr_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;     // one per grant, in order
    logic [31:0] rdata;
  } instr_rsp_t;

  typedef struct packed {
    logic [30:0] boot_addr;       // halfword address, lsb appended
    logic [31:0] jump_target_id;
    logic [31:0] jump_target_ex;
    logic [31:0] mepc;
    logic [31:0] depc;
    logic [31:0] pc;              // current pc, fence.i base
    logic [23:0] trap_base_addr;  // mtvec upper bits
    logic [29:0] dm_halt_addr;
    logic [5:0]  exc_vec;         // interrupt id for vectoring
  } pc_sources_t;

endpackage

/* if_stage.sv */
// instruction fetch stage
module if_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,                 // fetch enable from controller
  input  logic                   pc_set_i,              // redirect this cycle
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  fetch_pkg::trap_mux_e   trap_addr_mux_i,
  input  fetch_pkg::pc_sources_t sources_i,
  input  logic                   clear_instr_valid_i,
  input  logic                   halt_if_i,
  input  logic                   id_ready_i,
  input  fetch_pkg::instr_rsp_t  instr_rsp_i,
  output fetch_pkg::instr_req_t  instr_req_o,
  output logic                   instr_valid_id_o,
  output logic [31:0]            instr_rdata_id_o,
  output logic [31:0]            branch_target_o
);
  import fetch_pkg::*;

  issue_state_e issue_q;
  issue_state_e issue_n;
  logic         branch_req;
  logic         fetch_valid;
  logic         fetch_ready;
  logic         valid;          // word on offer to decode
  logic         if_valid;       // decode takes it
  logic [31:0]  fetch_rdata;
  logic [31:0]  fetch_addr;

  pc_select pc_select_inst (
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .trap_addr_mux_i (trap_addr_mux_i),
    .sources_i       (sources_i),
    .fetch_addr_o    (fetch_addr)
  );

  assign branch_target_o = fetch_addr;

  prefetch_buffer prefetch_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_req),
    .branch_addr_i (fetch_addr),
    .fetch_ready_i (fetch_ready),
    .bus_rsp_i     (instr_rsp_i),
    .fetch_valid_o (fetch_valid),
    .fetch_rdata_o (fetch_rdata),
    .bus_req_o     (instr_req_o)
  );

  //////////////////////////////////////////////////
  // issue fsm
  //////////////////////////////////////////////////
  always_comb begin
    issue_n    = issue_q;
    branch_req = 1'b0;
    unique case (issue_q)
      ISSUE_IDLE: if (req_i) begin
        branch_req = 1'b1;     // boot redirect on first request
        issue_n    = ISSUE_WAIT;
      end
      ISSUE_WAIT: issue_n = ISSUE_WAIT;   // serving words from here on
      default:    issue_n = ISSUE_IDLE;
    endcase
    if (pc_set_i) begin
      branch_req = 1'b1;
      issue_n    = ISSUE_WAIT;
    end
  end

  assign valid       = (issue_q == ISSUE_WAIT) & fetch_valid & ~pc_set_i;
  assign if_valid    = valid & id_ready_i & ~halt_if_i;
  assign fetch_ready = if_valid & req_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) issue_q <= ISSUE_IDLE;
    else        issue_q <= issue_n;
  end

  // if/id register, frozen while decode stalls
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o <= 1'b0;
      instr_rdata_id_o <= '0;
    end else if (fetch_ready) begin
      instr_valid_id_o <= 1'b1;
      instr_rdata_id_o <= fetch_rdata;
    end else if (clear_instr_valid_i) begin
      instr_valid_id_o <= 1'b0;     // data kept, only valid drops
    end
  end

endmodule

/* outstanding_counter.sv */
// outstanding bus transaction counter
module outstanding_counter (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        grant_i,
  input  logic                        response_i,
  input  logic                        flush_i,
  output logic [fetch_pkg::CNT_W-1:0] outstanding_o,   // all unanswered, stale included
  output logic                        discard_o        // drop the word arriving now
);
  import fetch_pkg::*;

  logic [CNT_W-1:0] out_q;
  logic [CNT_W-1:0] out_n;
  logic [CNT_W-1:0] disc_q;
  logic [CNT_W-1:0] disc_n;

  assign out_n     = out_q + CNT_W'(grant_i) - CNT_W'(response_i);
  assign discard_o = response_i & (disc_q != '0);   // stale ones come back first

  always_comb begin
    disc_n = disc_q;
    if (flush_i) begin
      disc_n = out_n;                  // everything still in flight is stale
    end else if (discard_o) begin
      disc_n = disc_q - CNT_W'(1);
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      out_q  <= '0;
      disc_q <= '0;
    end else begin
      out_q  <= out_n;
      disc_q <= disc_n;
    end
  end

  assign outstanding_o = out_q;

  a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
    response_i |-> out_q != '0)
    else $error("outstanding_counter: response without grant");

endmodule

/* pc_select.sv */
// next fetch address selection
module pc_select (
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  fetch_pkg::trap_mux_e   trap_addr_mux_i,
  input  fetch_pkg::pc_sources_t sources_i,
  output logic [31:0]            fetch_addr_o
);
  import fetch_pkg::*;

  logic [23:0] trap_base;
  logic [31:0] exc_pc;
  logic [31:0] addr_n;

  //////////////////////////////////////////////////
  // trap handler address
  //////////////////////////////////////////////////
  always_comb begin
    // only machine mode exists, user falls back to it
    unique case (trap_addr_mux_i)
      TRAP_MACHINE: trap_base = sources_i.trap_base_addr;
      default:      trap_base = sources_i.trap_base_addr;
    endcase

    unique case (exc_pc_mux_i)
      EXC_PC_EXCEPTION: exc_pc = {trap_base, 8'h00};               // all exceptions at base
      // base, zero, vector, word offset is 33 bits, base msb falls off the top
      EXC_PC_IRQ:       exc_pc = {trap_base[22:0], 1'b0, sources_i.exc_vec, 2'b00};
      EXC_PC_DEBUG:     exc_pc = {sources_i.dm_halt_addr, 2'b00};
      default:          exc_pc = {trap_base, 8'h00};
    endcase
  end

  //////////////////////////////////////////////////
  // source mux
  //////////////////////////////////////////////////
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT:      addr_n = {sources_i.boot_addr, 1'b0};
      PC_JUMP:      addr_n = sources_i.jump_target_id;
      PC_BRANCH:    addr_n = sources_i.jump_target_ex;
      PC_EXCEPTION: addr_n = exc_pc;
      PC_MRET:      addr_n = sources_i.mepc;   // return from trap
      PC_DRET:      addr_n = sources_i.depc;   // return from debug
      PC_FENCEI:    addr_n = sources_i.pc + 32'd4; // reload from next instr
      default:      addr_n = '0;
    endcase
  end

  assign fetch_addr_o = {addr_n[31:1], 1'b0};  // never odd

endmodule

/* prefetch_buffer.sv */
// prefetch buffer
module prefetch_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  logic                  branch_i,
  input  logic [31:0]           branch_addr_i,
  input  logic                  fetch_ready_i,   // word consumed this cycle
  input  fetch_pkg::instr_rsp_t bus_rsp_i,
  output logic                  fetch_valid_o,
  output logic [31:0]           fetch_rdata_o,
  output fetch_pkg::instr_req_t bus_req_o
);
  import fetch_pkg::*;

  logic             grant;
  logic             discard;
  logic             space;
  logic             flush;
  logic             stale_q;       // held request predates the last branch
  logic [CNT_W-1:0] fifo_cnt;
  logic [CNT_W-1:0] outstanding;
  logic [CNT_W:0]   used;

  // words buffered plus words on their way back
  assign used  = {1'b0, fifo_cnt} + {1'b0, outstanding};
  assign space = (used < FIFO_DEPTH);

  // a stale grant gets flushed too, so its response lands in discard
  assign flush = branch_i | (stale_q & grant);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) stale_q <= 1'b0;
    else if (branch_i && bus_req_o.req && !bus_rsp_i.gnt) stale_q <= 1'b1;
    else if (grant) stale_q <= 1'b0;
  end

  fetch_bus_fsm bus_fsm_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .space_i       (space),
    .bus_rsp_i     (bus_rsp_i),
    .bus_req_o     (bus_req_o),
    .grant_o       (grant)
  );

  outstanding_counter cnt_inst (
    .clk (clk), .rst_n (rst_n),
    .grant_i (grant), .response_i (bus_rsp_i.rvalid), .flush_i (flush),
    .outstanding_o (outstanding), .discard_o (discard)
  );

  fetch_fifo fifo_inst (
    .clk (clk), .rst_n (rst_n), .flush_i (flush),
    .push_i (bus_rsp_i.rvalid & ~discard), .push_data_i (bus_rsp_i.rdata),
    .pop_i (fetch_ready_i),
    .valid_o (fetch_valid_o), .rdata_o (fetch_rdata_o), .count_o (fifo_cnt)
  );

endmodule

/* run.sh */
#!/bin/sh
# build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_if_stage -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

/* tb_if_stage.sv */
// fetch stage testbench
module tb_if_stage;
  import fetch_pkg::*;

  localparam logic [31:0] DATA_KEY  = 32'h5a3c_96e1;
  localparam int          NUM_TESTS = 6;

  logic          clk;
  logic          rst_n;
  logic          req;
  logic          pc_set;
  logic          clear_valid;
  logic          halt_if;
  logic          id_ready;
  pc_mux_e       pc_mux;
  exc_pc_mux_e   exc_mux;
  trap_mux_e     trap_mux;
  pc_sources_t   sources;
  instr_rsp_t    instr_rsp;
  instr_req_t    instr_req;
  logic          instr_valid_id;
  logic [31:0]   instr_rdata_id;
  logic [31:0]   branch_target;
  logic [31:0]   exp_pc;        // address of the next word decode should see
  logic          new_word;      // IF/ID loaded at the last edge
  logic          booted;
  int            in_flight;     // grants minus responses
  int            err_cnt = 0;
  int            err_at_start = 0;
  int            test_cnt = 0;
  int            fail_cnt = 0;

  if_stage if_stage_inst (
    .clk (clk), .rst_n (rst_n), .req_i (req), .pc_set_i (pc_set),
    .pc_mux_i (pc_mux), .exc_pc_mux_i (exc_mux), .trap_addr_mux_i (trap_mux),
    .sources_i (sources), .clear_instr_valid_i (clear_valid), .halt_if_i (halt_if),
    .id_ready_i (id_ready), .instr_rsp_i (instr_rsp), .instr_req_o (instr_req),
    .instr_valid_id_o (instr_valid_id), .instr_rdata_id_o (instr_rdata_id),
    .branch_target_o (branch_target)
  );

  tb_imem #(.DATA_KEY (DATA_KEY)) imem_inst (
    .clk (clk), .rst_n (rst_n), .req_i (instr_req), .rsp_o (instr_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // target address rule, user trap mode behaves as machine
  function automatic logic [31:0] target_addr(pc_mux_e mux, exc_pc_mux_e exc, pc_sources_t s);
    logic [32:0] irq_full;   // base, zero, vector, word offset
    logic [31:0] t;
    irq_full = {s.trap_base_addr, 1'b0, s.exc_vec, 2'b00};
    case (mux)
      PC_BOOT:   t = {s.boot_addr, 1'b0};
      PC_JUMP:   t = s.jump_target_id;
      PC_BRANCH: t = s.jump_target_ex;
      PC_MRET:   t = s.mepc;
      PC_DRET:   t = s.depc;
      PC_FENCEI: t = s.pc + 32'd4;
      default: begin
        case (exc)
          EXC_PC_IRQ:   t = irq_full[31:0];      // top base bit is lost
          EXC_PC_DEBUG: t = {s.dm_halt_addr, 2'b00};
          default:      t = {s.trap_base_addr, 8'h00};
        endcase
      end
    endcase
    return {t[31:1], 1'b0};
  endfunction

  //////////////////////////////////////////////////
  // reference model of the stream
  //////////////////////////////////////////////////
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= 0;
      new_word  <= 1'b0;
      booted    <= 1'b0;
      exp_pc    <= '0;
    end else begin
      in_flight <= in_flight + int'(instr_req.req && instr_rsp.gnt) - int'(instr_rsp.rvalid);
      new_word  <= if_stage_inst.fetch_ready;
      booted    <= booted | req;
      if (pc_set) exp_pc <= target_addr(pc_mux, exc_mux, sources);
      else if (req && !booted) exp_pc <= {sources.boot_addr, 1'b0};   // boot redirect
      else if (new_word) exp_pc <= exp_pc + 32'd4;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !req && !booted |-> !instr_req.req && !instr_valid_id)
    else begin $display("fetch activity seen before req_i was raised"); err_cnt++; end
  a_stream: assert property (@(posedge clk) disable iff (!rst_n)
    new_word |-> (instr_rdata_id ^ DATA_KEY) == exp_pc)
    else begin
      $display("** Error: instr_rdata_id_o = %h, expected %h",
               $sampled(instr_rdata_id), $sampled(exp_pc) ^ DATA_KEY);
      err_cnt++;
    end
  a_valid: assert property (@(posedge clk) disable iff (!rst_n)
    new_word |-> instr_valid_id)
    else begin
      $display("** Error: instr_valid_id_o = %h, expected %h", $sampled(instr_valid_id), 1'b1);
      err_cnt++;
    end
  a_target: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set |-> branch_target == target_addr(pc_mux, exc_mux, sources))
    else begin
      $display("** Error: branch_target_o = %h, expected %h", $sampled(branch_target),
               target_addr($sampled(pc_mux), $sampled(exc_mux), $sampled(sources)));
      err_cnt++;
    end
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!id_ready || halt_if) && !clear_valid |=> $stable(instr_rdata_id) && $stable(instr_valid_id))
    else begin $display("IF/ID register changed while decode was stalled"); err_cnt++; end
  a_clear: assert property (@(posedge clk) disable iff (!rst_n)
    clear_valid && (!id_ready || halt_if) |=> !instr_valid_id)
    else begin $display("valid stayed high after clear_instr_valid_i"); err_cnt++; end
  a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req.req && !instr_rsp.gnt |=> instr_req.req && $stable(instr_req.addr))
    else begin $display("instruction request dropped or moved before its grant"); err_cnt++; end
  a_in_flight: assert property (@(posedge clk) disable iff (!rst_n) in_flight <= FIFO_DEPTH)
    else begin $display("more transactions outstanding than the buffer holds"); err_cnt++; end

  // count accepted words, give up after 50 cycles per word
  task automatic wait_words(input int n);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < n && cycles < n * 50) begin
      @(negedge clk);
      if (new_word) seen++;
      cycles++;
    end
    if (seen < n) begin
      $display("only %0d of %0d instructions reached decode", seen, n);
      err_cnt++;
    end
  endtask

  // one-cycle pc_set, issued once a fetch is in flight
  task automatic redirect(input pc_mux_e mux, input exc_pc_mux_e exc, input trap_mux_e trap);
    do @(negedge clk); while (in_flight == 0);
    @(posedge clk);
    pc_mux   <= mux;
    exc_mux  <= exc;
    trap_mux <= trap;
    pc_set   <= 1'b1;
    @(posedge clk);
    pc_set   <= 1'b0;
    pc_mux   <= PC_BOOT;
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (err_cnt == err_at_start) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_at_start);
    end
    err_at_start = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  initial begin
    rst_n       = 1'b0;
    req         = 1'b0;
    pc_set      = 1'b0;
    pc_mux      = PC_BOOT;
    exc_mux     = EXC_PC_EXCEPTION;
    trap_mux    = TRAP_MACHINE;
    clear_valid = 1'b0;
    halt_if     = 1'b0;
    id_ready    = 1'b1;
    sources     = '{boot_addr: 31'h40, jump_target_id: 32'h1000, jump_target_ex: 32'h2000,
                    mepc: 32'h3004, depc: 32'h4008, pc: 32'h500c, trap_base_addr: 24'h60,
                    dm_halt_addr: 30'h1c00, exc_vec: 6'h0b};
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (20) @(posedge clk);
    finish_test("idle after reset");
    @(posedge clk);
    req <= 1'b1;
    wait_words(8);
    finish_test("boot and sequential fetch");
    redirect(PC_JUMP, EXC_PC_EXCEPTION, TRAP_MACHINE);
    wait_words(3);
    redirect(PC_BRANCH, EXC_PC_EXCEPTION, TRAP_MACHINE);
    wait_words(3);
    redirect(PC_MRET, EXC_PC_EXCEPTION, TRAP_MACHINE);
    wait_words(3);
    redirect(PC_DRET, EXC_PC_EXCEPTION, TRAP_MACHINE);
    wait_words(3);
    redirect(PC_FENCEI, EXC_PC_EXCEPTION, TRAP_MACHINE);
    wait_words(3);
    finish_test("redirects");
    redirect(PC_EXCEPTION, EXC_PC_EXCEPTION, TRAP_USER);   // falls back to machine
    wait_words(3);
    redirect(PC_EXCEPTION, EXC_PC_IRQ, TRAP_MACHINE);
    wait_words(3);
    redirect(PC_EXCEPTION, EXC_PC_DEBUG, TRAP_MACHINE);
    wait_words(3);
    finish_test("trap targets");
    @(posedge clk);
    id_ready <= 1'b0;               // decode stall
    repeat (6) @(posedge clk);
    id_ready <= 1'b1;
    halt_if  <= 1'b1;               // then a halt
    repeat (2) @(posedge clk);
    clear_valid <= 1'b1;
    @(posedge clk);
    clear_valid <= 1'b0;
    repeat (4) @(posedge clk);
    halt_if <= 1'b0;
    wait_words(4);
    finish_test("stalls");
    id_ready <= 1'b0;               // let the buffer fill, requests must pause
    repeat (8) @(posedge clk);
    id_ready <= 1'b1;
    wait_words(6);
    finish_test("bus rule");
    $display("tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(NUM_TESTS * 2000);
    $display("run stopped by the watchdog after %0d time units", NUM_TESTS * 2000);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* tb_imem.sv */
// instruction memory model
module tb_imem #(
  parameter logic [31:0] DATA_KEY = 32'h0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fetch_pkg::instr_req_t req_i,
  output fetch_pkg::instr_rsp_t rsp_o
);
  import fetch_pkg::*;

  logic [1:0]  gnt_wait;     // cycles left before the next grant
  logic        gnt;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic [31:0] addr_q [$];   // granted addresses, oldest first
  int          due_q [$];    // cycle each response may go out
  int          cyc;

  initial void'($urandom(32'he9759fbf));  // one seed for the whole run

  assign gnt   = req_i.req && (gnt_wait == 2'd0);   // same-cycle grant when ready
  assign rsp_o = '{gnt: gnt, rvalid: rvalid_q, rdata: rdata_q};

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_wait <= 2'd0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
      cyc = 0;
      addr_q.delete();
      due_q.delete();
    end else begin
      cyc = cyc + 1;
      if (gnt) begin
        addr_q.push_back(req_i.addr);
        due_q.push_back(cyc + int'($urandom_range(3, 0)));   // 0..3 extra cycles
        gnt_wait <= 2'($urandom_range(3, 0));
      end else if (req_i.req) begin
        gnt_wait <= gnt_wait - 2'd1;
      end
      // at most one response per cycle, in grant order
      rvalid_q <= 1'b0;
      if (due_q.size() != 0 && due_q[0] <= cyc) begin
        rvalid_q <= 1'b1;
        rdata_q  <= addr_q.pop_front() ^ DATA_KEY;   // data tells its own address
        void'(due_q.pop_front());
      end
    end
  end

endmodule
